//--- rtl/bram_sdp.sv
/* simple dual-port memory
   one write port, one registered read port */
`timescale 1ns/100ps
`default_nettype none

module bram_sdp #(
    parameter  int width = 1,    // bits per word
    parameter  int depth = 128,  // words
    localparam int addrw = $clog2(depth)
) (
    input  wire logic             clk_pix,
    input  wire logic             we,
    input  wire logic [addrw-1:0] addr_write,
    input  wire logic [addrw-1:0] addr_read,
    input  wire logic [width-1:0] data_in,
    output logic      [width-1:0] data_out  // one cycle after addr_read
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk_pix) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];  // old data on same-address collision
    end

endmodule

`default_nettype wire

//--- rtl/display_timings.sv
/* display timing generator
   position counters, active-low sync, data enable, frame end strobe */
`timescale 1ns/100ps
`default_nettype none

module display_timings #(
    parameter int cordw        = 10,   // coordinate width
    parameter int h_res        = 640,  // active pixels
    parameter int v_res        = 480,
    parameter int h_full       = 800,  // incl blanking
    parameter int v_full       = 525,
    parameter int h_sync_start = 656,
    parameter int h_sync_end   = 752,
    parameter int v_sync_start = 490,
    parameter int v_sync_end   = 492
) (
    input  wire logic             clk_pix,
    input  wire logic             rst,
    output logic      [cordw-1:0] sx,
    output logic      [cordw-1:0] sy,
    output logic                  hsync,     // active low
    output logic                  vsync,     // active low
    output logic                  de,        // active area
    output logic                  frame_end  // last pixel of last line
);

    logic [cordw-1:0] sx_next;
    logic [cordw-1:0] sy_next;

    always_comb begin
        sx_next = (sx == cordw'(h_full-1)) ? '0 : sx + 1'b1;
        sy_next = sy;
        if (sx == cordw'(h_full-1))  // end of line
            sy_next = (sy == cordw'(v_full-1)) ? '0 : sy + 1'b1;
    end

    // decode from next position so outputs line up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx        <= cordw'(h_full-1);  // first edge lands on 0,0
            sy        <= cordw'(v_full-1);
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            de        <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            sx        <= sx_next;
            sy        <= sy_next;
            hsync     <= !(sx_next >= cordw'(h_sync_start) && sx_next < cordw'(h_sync_end));
            vsync     <= !(sy_next >= cordw'(v_sync_start) && sy_next < cordw'(v_sync_end));
            de        <= (sx_next < cordw'(h_res)) && (sy_next < cordw'(v_res));
            frame_end <= (sx_next == cordw'(h_full-1)) && (sy_next == cordw'(v_full-1));
        end
    end

endmodule

`default_nettype wire

//--- rtl/life_display.sv
/* life display top level
   seed loader, generation sequencer, double-buffered frame store, colour out */
`timescale 1ns/100ps
`default_nettype none

module life_display #(
    parameter int h_res        = 640,
    parameter int v_res        = 480,
    parameter int h_full       = 800,
    parameter int v_full       = 525,
    parameter int h_sync_start = 656,
    parameter int h_sync_end   = 752,
    parameter int v_sync_start = 490,
    parameter int v_sync_end   = 492,
    parameter int world_w      = 80,   // world_w * scale == h_res
    parameter int world_h      = 60,
    parameter int scale        = 8,
    parameter int gen_frames   = 15,   // frames per generation
    parameter int cordw        = 10
) (
    input  wire logic                          clk_pix,
    input  wire logic                          rst,
    input  wire logic                          load_req,   // four-phase with load_ack
    input  wire logic                          load_cell,
    output logic                               load_ack,
    output logic                               hsync,
    output logic                               vsync,
    output logic      [life_pkg::colour_w-1:0] vga_r,
    output logic      [life_pkg::colour_w-1:0] vga_g,
    output logic      [life_pkg::colour_w-1:0] vga_b
);

    localparam int cw          = life_pkg::colour_w;
    localparam int cells       = world_w * world_h;
    localparam int fb_addrw    = $clog2(2 * cells);
    localparam int fetch_addrw = $clog2(cells);
    localparam int fcw         = $clog2(gen_frames + 1);

    logic [cordw-1:0] sx;
    logic [cordw-1:0] sy;
    logic             de;
    logic             frame_end;

    display_timings #(
        .cordw(cordw), .h_res(h_res), .v_res(v_res), .h_full(h_full), .v_full(v_full),
        .h_sync_start(h_sync_start), .h_sync_end(h_sync_end),
        .v_sync_start(v_sync_start), .v_sync_end(v_sync_end)
    ) timings (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .frame_end
    );

    // seed loader, one cell per handshake into buffer 0
    logic [fb_addrw-1:0] load_addr;
    logic                load_we;
    logic                seeded;  // whole world loaded

    always_comb load_we = load_req && !load_ack && !seeded;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            load_addr <= '0;
            load_ack  <= 1'b0;
            seeded    <= 1'b0;
        end else if (load_we) begin
            load_ack  <= 1'b1;
            load_addr <= load_addr + 1'b1;
            if (load_addr == fb_addrw'(cells-1)) seeded <= 1'b1;
        end else if (load_ack && !load_req) begin
            load_ack <= 1'b0;
        end
    end

    // generation sequencer
    logic [fcw-1:0] frame_cnt;
    logic           front_buf;
    logic           life_start;
    logic           life_done;
    logic           seeded_d;
    logic           gen_ready;  // back buffer holds the next generation
    logic           disp_swap;  // row 0 of the next frame comes from the back buffer

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            frame_cnt  <= '0;
            front_buf  <= 1'b0;
            life_start <= 1'b0;
            seeded_d   <= 1'b0;
            gen_ready  <= 1'b0;
        end else begin
            seeded_d   <= seeded;
            life_start <= seeded && !seeded_d;  // first generation right after load
            if (!seeded) begin
                frame_cnt <= '0;
            end else if (frame_end) begin
                if (frame_cnt == fcw'(gen_frames-1)) begin
                    frame_cnt  <= '0;
                    front_buf  <= ~front_buf;
                    life_start <= 1'b1;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            if (life_start) gen_ready <= 1'b0;
            else if (life_done) gen_ready <= 1'b1;
        end
    end

    // row 0 is fetched in the last line, before the swap at frame_end
    always_comb begin
        disp_swap = seeded && gen_ready && frame_cnt == fcw'(gen_frames-1)
                    && sy == cordw'(v_full-1);
    end

    // frame store, engine owns the read port while fetch is idle
    logic                   fetch_idle;
    logic [fetch_addrw-1:0] fetch_addr;
    logic [fb_addrw-1:0]    base_front;
    logic [fb_addrw-1:0]    base_back;
    logic [fb_addrw-1:0]    disp_base;
    logic [fb_addrw-1:0]    cell_addr;
    logic                   cell_we;
    logic                   cell_in;
    logic                   fb_we;
    logic                   fb_din;
    logic                   fb_dout;
    logic [fb_addrw-1:0]    fb_addr_read;
    logic [fb_addrw-1:0]    fb_addr_write;
    logic                   pix_alive;

    always_comb begin
        base_front    = front_buf ? fb_addrw'(cells) : '0;
        base_back     = front_buf ? '0 : fb_addrw'(cells);
        disp_base     = (front_buf ^ disp_swap) ? fb_addrw'(cells) : '0;
        fb_addr_read  = fetch_idle ? cell_addr : disp_base + fb_addrw'(fetch_addr);
        fb_we         = seeded ? cell_we : load_we;  // loader only before seeded
        fb_addr_write = seeded ? cell_addr : load_addr;
        fb_din        = seeded ? cell_in : load_cell;
    end

    bram_sdp #(.width(1), .depth(2 * cells)) frame_store (
        .clk_pix, .we(fb_we), .addr_write(fb_addr_write), .addr_read(fb_addr_read),
        .data_in(fb_din), .data_out(fb_dout)
    );

    life_engine #(.world_w(world_w), .world_h(world_h)) engine (
        .clk_pix, .rst, .start(life_start), .run(fetch_idle),
        .base_read(base_front), .base_write(base_back),
        .cell_addr, .cell_we, .cell_in, .cell_out(fb_dout), .done(life_done)
    );

    line_fetch #(
        .cordw(cordw), .h_res(h_res), .h_full(h_full), .v_full(v_full),
        .world_w(world_w), .world_h(world_h), .scale(scale)
    ) fetch (
        .clk_pix, .rst, .sx, .sy, .fb_addr(fetch_addr), .fb_data(fb_dout),
        .pix_alive, .idle(fetch_idle)
    );

    // colour out, blank outside the active area
    logic [3*cw-1:0] colour;

    always_comb begin
        colour = pix_alive ? life_pkg::colour_alive : life_pkg::colour_dead;
        vga_r  = de ? colour[3*cw-1 -: cw] : '0;
        vga_g  = de ? colour[2*cw-1 -: cw] : '0;
        vga_b  = de ? colour[cw-1 -: cw] : '0;
    end

endmodule

`default_nettype wire

//--- rtl/life_engine.sv
/* life engine
   nine-read neighbour count per cell, next state written to the back buffer
   advances only while run is high */
`timescale 1ns/100ps
`default_nettype none

module life_engine #(
    parameter  int world_w = 80,
    parameter  int world_h = 60,
    localparam int cells   = world_w * world_h,
    localparam int addrw   = $clog2(2 * cells),  // both buffers
    localparam int xw      = $clog2(world_w),
    localparam int yw      = $clog2(world_h)
) (
    input  wire logic             clk_pix,
    input  wire logic             rst,
    input  wire logic             start,       // one-cycle pulse
    input  wire logic             run,         // frame store granted
    input  wire logic [addrw-1:0] base_read,   // front buffer offset
    input  wire logic [addrw-1:0] base_write,  // back buffer offset
    output logic      [addrw-1:0] cell_addr,
    output logic                  cell_we,
    output logic                  cell_in,     // next state
    input  wire logic             cell_out,    // read data, one cycle late
    output logic                  done
);

    life_pkg::engine_state_t state;

    logic [addrw-1:0] idx;      // linear index of current cell
    logic [xw-1:0]    cx;
    logic [yw-1:0]    cy;
    logic [1:0]       ox;       // neighbour offset, 1 is centre
    logic [1:0]       oy;
    logic [3:0]       cnt;      // live neighbours so far
    logic             alive;    // centre cell
    logic             rd_pend;  // read in flight
    logic             rd_self;  // in-flight read is the centre
    logic             x_ok;
    logic             y_ok;
    logic [addrw-1:0] nbr_off;

    always_comb begin
        // no wrap at the edges
        x_ok = !((ox == 2'd0 && cx == '0) || (ox == 2'd2 && cx == xw'(world_w-1)));
        y_ok = !((oy == 2'd0 && cy == '0) || (oy == 2'd2 && cy == yw'(world_h-1)));
        // (oy-1)*world_w + (ox-1), modulo the address width
        nbr_off = addrw'(oy) * addrw'(world_w) + addrw'(ox) - addrw'(world_w + 1);
        if (state == life_pkg::es_write_cell)
            cell_addr = base_write + idx;
        else
            cell_addr = base_read + idx + nbr_off;
        cell_we = (state == life_pkg::es_write_cell) && run && !rd_pend;
        cell_in = (cnt == 4'd3) || (alive && cnt == 4'd2);  // birth on 3, survive on 2 or 3
        done    = (state == life_pkg::es_done);
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state   <= life_pkg::es_idle;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= 1'b0;
            if (rd_pend) begin  // in-flight data lands even while paused
                if (rd_self) alive <= cell_out;
                else cnt <= cnt + 4'(cell_out);
            end
            case (state)
                life_pkg::es_idle: begin
                    idx <= '0;
                    cx  <= '0;
                    cy  <= '0;
                    ox  <= '0;
                    oy  <= '0;
                    if (start) state <= life_pkg::es_clear;
                end
                life_pkg::es_clear: if (run) begin
                    cnt   <= '0;
                    alive <= 1'b0;
                    ox    <= '0;
                    oy    <= '0;
                    state <= life_pkg::es_read_nbr;
                end
                life_pkg::es_read_nbr: if (run) begin
                    rd_pend <= x_ok && y_ok;  // off-world reads skipped, count as dead
                    rd_self <= (ox == 2'd1) && (oy == 2'd1);
                    if (ox == 2'd2) begin
                        ox <= '0;
                        oy <= oy + 1'b1;
                        if (oy == 2'd2) state <= life_pkg::es_write_cell;
                    end else begin
                        ox <= ox + 1'b1;
                    end
                end
                life_pkg::es_write_cell: if (cell_we) begin  // waits for last read
                    if (idx == addrw'(cells-1)) begin
                        state <= life_pkg::es_done;
                    end else begin
                        state <= life_pkg::es_clear;
                        idx   <= idx + 1'b1;
                        if (cx == xw'(world_w-1)) begin
                            cx <= '0;
                            cy <= cy + 1'b1;
                        end else begin
                            cx <= cx + 1'b1;
                        end
                    end
                end
                life_pkg::es_done: state <= life_pkg::es_idle;
                default: state <= life_pkg::es_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/life_pkg.sv
/* shared definitions for the life display
   colour words, line fetch and life engine state encodings */
`default_nettype none

package life_pkg;

    localparam int colour_w = 4;  // bits per channel

    // 12-bit rgb words
    localparam logic [3*colour_w-1:0] colour_alive = 12'hfff;  // white
    localparam logic [3*colour_w-1:0] colour_dead  = 12'h009;  // dark blue

    // line fetch, copies world rows into the line memory
    typedef enum logic [2:0] {
        fs_idle,        // frame store free for the engine
        fs_start,       // new frame, rewind counters
        fs_await_pos,   // wait for horizontal blanking
        fs_start_line,  // decide whether this line needs a row
        fs_read_fb,     // one cell per cycle into line memory
        fs_line_done
    } fetch_state_t;

    // life engine, one pass over the world per generation
    typedef enum logic [2:0] {
        es_idle,
        es_clear,       // reset count for next cell
        es_read_nbr,    // nine reads, neighbours plus centre
        es_write_cell,  // store next state in back buffer
        es_done         // one-cycle done pulse
    } engine_state_t;

endpackage

`default_nettype wire

//--- rtl/line_fetch.sv
/* line fetch
   copies world rows into a line memory in horizontal blanking
   and replays each cell as a scale by scale block */
`timescale 1ns/100ps
`default_nettype none

module line_fetch #(
    parameter  int cordw    = 10,
    parameter  int h_res    = 640,
    parameter  int h_full   = 800,
    parameter  int v_full   = 525,
    parameter  int world_w  = 80,
    parameter  int world_h  = 60,
    parameter  int scale    = 8,   // pixels per cell side
    localparam int fb_addrw = $clog2(world_w * world_h),
    localparam int lb_addrw = $clog2(world_w),
    localparam int rowcw    = $clog2(world_h),
    localparam int rptw     = $clog2(scale + 1)
) (
    input  wire logic                clk_pix,
    input  wire logic                rst,
    input  wire logic [cordw-1:0]    sx,
    input  wire logic [cordw-1:0]    sy,
    output logic      [fb_addrw-1:0] fb_addr,    // cell index in the front buffer
    input  wire logic                fb_data,
    output logic                     pix_alive,  // aligned with sx
    output logic                     idle        // engine may use the frame store
);

    life_pkg::fetch_state_t state;
    life_pkg::fetch_state_t state_next;

    logic                line_mem [world_w];
    logic [lb_addrw-1:0] lb_addr_write;
    logic [lb_addrw-1:0] lb_addr_write_d;  // matches memory latency
    logic                lb_we_d;
    logic [lb_addrw-1:0] lb_addr_read;
    logic [rowcw-1:0]    row_cnt;
    logic [rptw-1:0]     line_rpt;  // screen lines shown of this row
    logic [rptw-1:0]     pix_rpt;   // pixels shown of this cell
    logic                last_row;
    logic                last_cell;

    always_comb begin
        last_row  = (row_cnt == rowcw'(world_h-1));
        last_cell = (lb_addr_write == lb_addrw'(world_w-1));
        case (state)
            life_pkg::fs_idle:
                state_next = (sy == cordw'(v_full-1)) ? life_pkg::fs_start : life_pkg::fs_idle;
            life_pkg::fs_start:
                state_next = life_pkg::fs_await_pos;
            life_pkg::fs_await_pos:  // blanking starts at h_res
                state_next = (sx == cordw'(h_res)) ? life_pkg::fs_start_line
                                                   : life_pkg::fs_await_pos;
            life_pkg::fs_start_line:
                state_next = (line_rpt == '0) ? life_pkg::fs_read_fb : life_pkg::fs_await_pos;
            life_pkg::fs_read_fb:
                state_next = last_cell ? life_pkg::fs_line_done : life_pkg::fs_read_fb;
            life_pkg::fs_line_done:
                state_next = last_row ? life_pkg::fs_idle : life_pkg::fs_await_pos;
            default:
                state_next = life_pkg::fs_idle;
        endcase
        idle = (state == life_pkg::fs_idle);
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state   <= life_pkg::fs_idle;
            lb_we_d <= 1'b0;
        end else begin
            state   <= state_next;
            lb_we_d <= (state == life_pkg::fs_read_fb);
        end
    end

    // row and cell counters, line memory write
    always_ff @(posedge clk_pix) begin
        case (state)
            life_pkg::fs_start: begin
                fb_addr  <= '0;
                row_cnt  <= '0;
                line_rpt <= '0;
            end
            life_pkg::fs_await_pos: lb_addr_write <= '0;
            life_pkg::fs_start_line:
                line_rpt <= (line_rpt == rptw'(scale-1)) ? '0 : line_rpt + 1'b1;
            life_pkg::fs_read_fb: begin
                lb_addr_write <= lb_addr_write + 1'b1;
                fb_addr       <= fb_addr + 1'b1;
            end
            life_pkg::fs_line_done: row_cnt <= row_cnt + 1'b1;
            default: ;
        endcase
        lb_addr_write_d <= lb_addr_write;
        if (lb_we_d) line_mem[lb_addr_write_d] <= fb_data;  // frame store data one cycle late
    end

    // replay, read address preset two pixels early for one-cycle latency
    always_ff @(posedge clk_pix) begin
        if (sx == cordw'(h_full-2)) begin
            lb_addr_read <= '0;
            pix_rpt      <= '0;
        end else if (lb_addr_read < lb_addrw'(world_w-1)) begin
            pix_rpt <= (pix_rpt == rptw'(scale-1)) ? '0 : pix_rpt + 1'b1;
            if (pix_rpt == rptw'(scale-1)) lb_addr_read <= lb_addr_read + 1'b1;
        end
        pix_alive <= line_mem[lb_addr_read];
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/life_pkg.sv
rtl/display_timings.sv
rtl/bram_sdp.sv
rtl/life_engine.sv
rtl/line_fetch.sv
rtl/life_display.sv
tb/life_display_assert.sv
tb/tb_life_display.sv

//--- tb/life_display_assert.sv
/* bound checks on the engine link and the seed loader
   write grant, done after start, four-phase ack */
`timescale 1ns/100ps
`default_nettype none

module life_display_assert (
    input wire logic                   clk_pix,
    input wire logic                   rst,
    input wire logic                   start,
    input wire logic                   done,
    input wire logic                   cell_we,
    input wire life_pkg::fetch_state_t fetch_state,
    input wire logic                   load_req,
    input wire logic                   load_ack
);

    logic busy;      // engine pass in progress
    int   fails = 0; // failed assertions so far

    always_ff @(posedge clk_pix) begin
        if (rst) busy <= 1'b0;
        else if (start) busy <= 1'b1;
        else if (done) busy <= 1'b0;
    end

    // engine only writes while line fetch leaves the frame store alone
    we_needs_fetch_idle: assert property (@(posedge clk_pix) disable iff (rst)
        cell_we |-> fetch_state == life_pkg::fs_idle)
        else begin
            $error("cell_we high while line fetch is busy");
            fails++;
        end

    done_after_start: assert property (@(posedge clk_pix) disable iff (rst)
        done |-> busy)
        else begin
            $error("done without a preceding start");
            fails++;
        end

    ack_follows_req: assert property (@(posedge clk_pix) disable iff (rst)
        $rose(load_ack) |-> $past(load_req))
        else begin
            $error("load_ack rose without load_req");
            fails++;
        end

endmodule

// loader and engine signals both live in the top level
bind life_display life_display_assert checks (
    .clk_pix, .rst, .start(life_start), .done(life_done),
    .cell_we, .fetch_state(fetch.state), .load_req, .load_ack
);

`default_nettype wire

//--- tb/tb_life_display.sv
/* testbench for the life display
   random seed load, screen rebuild from sync, life model compare */
`timescale 1ns/100ps
`default_nettype none

module tb_life_display;

    localparam int h_res = 64, v_res = 48, h_full = 80, v_full = 56;
    localparam int hs0 = 68, hs1 = 72, vs0 = 50, vs1 = 52;  // sync edges
    localparam int ww = 8, wh = 6, scale = 8, gen_frames = 2;
    localparam int cw = life_pkg::colour_w;
    localparam int test_frames = 36;  // all tests plus margin
    localparam realtime limit = 2.0 * test_frames * v_full * h_full * 4.0;

    typedef bit world_t [wh][ww];

    logic clk_pix = 1'b0;
    logic rst, load_req, load_cell, load_ack, hsync, vsync;
    logic [cw-1:0] vga_r, vga_g, vga_b;

    int errors = 0;
    int checks = 0;
    int sync_errors = 0;  // blanking and sync failures
    int frames_seen = 0;
    logic [3*cw-1:0] img [wh][ww];    // cell centres being filled
    logic [3*cw-1:0] frame [wh][ww];  // last complete frame

    always #2 clk_pix = ~clk_pix;

    life_display #(
        .h_res(h_res), .v_res(v_res), .h_full(h_full), .v_full(v_full),
        .h_sync_start(hs0), .h_sync_end(hs1), .v_sync_start(vs0), .v_sync_end(vs1),
        .world_w(ww), .world_h(wh), .scale(scale), .gen_frames(gen_frames), .cordw(8)
    ) UUT (
        .clk_pix, .rst, .load_req, .load_cell, .load_ack, .hsync, .vsync, .vga_r, .vga_g,
        .vga_b
    );

    // screen monitor rebuilds position from sync falls
    int px, py, hs_len, vs_len;
    bit h_seen, v_seen, hs_prev, vs_prev;

    always @(negedge clk_pix) begin
        if (rst) begin
            h_seen = 0;
            v_seen = 0;
            hs_prev = 1;
            vs_prev = 1;
        end else begin
            px = (px == h_full-1) ? 0 : px + 1;
            if (px == 0) py = (py == v_full-1) ? 0 : py + 1;
            if (!hsync) hs_len++;
            if (!vsync) vs_len++;
            if (hs_prev && !hsync) begin
                px = hs0;
                h_seen = 1;
                hs_len = 1;
            end
            if (vs_prev && !vsync) begin
                py = vs0;
                v_seen = 1;
                vs_len = 1;
            end
            if (!hs_prev && hsync && h_seen) begin  // pulse width in pixels
                checks++;
                assert (hs_len == hs1 - hs0) else begin
                    $display("FAILED %0t hsync low for %0d, expected %0d", $time, hs_len,
                             hs1 - hs0);
                    errors++;
                    sync_errors++;
                end
            end
            if (!vs_prev && vsync && v_seen) begin  // width in whole lines
                checks++;
                assert (vs_len == (vs1 - vs0) * h_full) else begin
                    $display("FAILED %0t vsync low for %0d, expected %0d", $time, vs_len,
                             (vs1 - vs0) * h_full);
                    errors++;
                    sync_errors++;
                end
            end
            if (h_seen && v_seen) begin
                if (px >= h_res || py >= v_res) begin
                    checks++;
                    assert ({vga_r, vga_g, vga_b} == '0) else begin
                        $display("FAILED %0t vga_r/g/b in blanking got %h expected %h",
                                 $time, {vga_r, vga_g, vga_b}, 12'h000);
                        errors++;
                        sync_errors++;
                    end
                end else if (px % scale == scale/2 && py % scale == scale/2) begin
                    img[py/scale][px/scale] = {vga_r, vga_g, vga_b};  // block centre
                end
                if (px == 0 && py == v_res) begin  // active area done
                    frame = img;
                    frames_seen++;
                end
            end
            hs_prev = hsync;
            vs_prev = vsync;
        end
    end

    // life model with dead edges
    function automatic world_t step(input world_t w);
        world_t n;
        int c;
        for (int y = 0; y < wh; y++)
            for (int x = 0; x < ww; x++) begin
                c = 0;
                for (int dy = -1; dy <= 1; dy++)
                    for (int dx = -1; dx <= 1; dx++)
                        if ((dx != 0 || dy != 0) && x+dx >= 0 && x+dx < ww
                            && y+dy >= 0 && y+dy < wh)
                            c += w[y+dy][x+dx];
                n[y][x] = (c == 3) || (w[y][x] && c == 2);
            end
        return n;
    endfunction

    function automatic bit same_world(input world_t a, input world_t b);
        for (int y = 0; y < wh; y++)
            for (int x = 0; x < ww; x++)
                if (a[y][x] != b[y][x])
                    return 0;
        return 1;
    endfunction

    function automatic bit shows(input world_t w);
        for (int y = 0; y < wh; y++)
            for (int x = 0; x < ww; x++)
                if (frame[y][x] != (w[y][x] ? life_pkg::colour_alive : life_pkg::colour_dead))
                    return 0;
        return 1;
    endfunction

    task automatic wait_frame();
        int n;
        n = frames_seen;
        while (frames_seen == n) @(negedge clk_pix);
    endtask

    task automatic do_reset();
        rst = 1'b1;
        repeat (5) @(negedge clk_pix);
        rst = 1'b0;
    endtask

    // one cell per four-phase handshake
    task automatic load_world(input world_t w);
        int t;
        for (int y = 0; y < wh; y++)
            for (int x = 0; x < ww; x++) begin
                @(negedge clk_pix);
                load_cell = w[y][x];
                load_req = 1'b1;
                t = 0;
                while (!load_ack && t < 64) begin
                    @(negedge clk_pix);
                    t++;
                end
                checks++;
                assert (load_ack) else begin
                    $display("load of cell %0d,%0d was never acknowledged", x, y);
                    errors++;
                end
                load_req = 1'b0;
                t = 0;
                while (load_ack && t < 64) begin
                    @(negedge clk_pix);
                    t++;
                end
                checks++;
                assert (!load_ack) else begin
                    $display("load_ack stayed high after load_req dropped");
                    errors++;
                end
            end
    endtask

    // follow the display for a number of generations
    task automatic evolve(inout world_t cur, input int gens);
        world_t nxt;
        int since, reached;
        bit first, changed;
        since = 1;
        reached = 0;
        first = 1;
        while (reached < gens) begin
            wait_frame();
            nxt = step(cur);
            changed = !same_world(nxt, cur);
            checks++;
            if (shows(nxt) && (changed || since >= gen_frames)) begin
                if (changed && !first) begin
                    checks++;
                    assert (since >= gen_frames) else begin
                        $display("FAILED %0t frames per generation got %0d expected >= %0d",
                                 $time, since, gen_frames);
                        errors++;
                    end
                end
                cur = nxt;  // model follows the display
                reached++;
                since = 1;
                first = 0;
            end else begin
                assert (shows(cur)) else begin
                    $display("displayed frame matches neither the current nor next generation");
                    errors++;
                end
                since++;
            end
        end
    endtask

    task automatic report(input string name, input int n_err);
        $display("%s: %s (%0d errors)", name, (n_err == 0) ? "ok" : "failed", n_err);
    endtask

    world_t seed, world, still;
    int err0, t;
    logic [3*cw-1:0] expect_col;

    initial begin
        rst = 1'b1;
        load_req = 1'b0;
        load_cell = 1'b0;
        void'($urandom(32'hfa577d4c));
        foreach (seed[y, x]) seed[y][x] = $urandom % 2;
        do_reset();

        err0 = errors;  // test 1
        load_world(seed);
        @(negedge clk_pix);
        load_req = 1'b1;  // one cell too many
        t = 0;
        while (!load_ack && t < 200) begin
            @(negedge clk_pix);
            t++;
        end
        checks++;
        assert (!load_ack) else begin
            $display("an extra load request after a full world was acknowledged");
            errors++;
        end
        load_req = 1'b0;
        report("test 1 seed load, extra request refused", errors - err0);

        err0 = errors;  // test 2
        wait_frame();
        for (int y = 0; y < wh; y++)
            for (int x = 0; x < ww; x++) begin
                expect_col = seed[y][x] ? life_pkg::colour_alive : life_pkg::colour_dead;
                checks++;
                assert (frame[y][x] == expect_col) else begin
                    $display("FAILED %0t vga_r/g/b cell %0d,%0d got %h expected %h",
                             $time, x, y, frame[y][x], expect_col);
                    errors++;
                end
            end
        report("test 2 seed display", errors - err0);

        err0 = errors;  // tests 3 and 4
        world = seed;
        evolve(world, 10);
        report("test 3/4 evolution and pacing", errors - err0);

        err0 = errors;  // test 6 block plus two singles
        foreach (still[y, x]) still[y][x] = 0;
        still[1][1] = 1;
        still[1][2] = 1;
        still[2][1] = 1;
        still[2][2] = 1;
        still[1][5] = 1;
        still[4][6] = 1;
        do_reset();
        load_world(still);
        world = still;
        evolve(world, 2);
        still[1][5] = 0;  // singles die and the block stays
        still[4][6] = 0;
        checks++;
        assert (shows(still)) else begin
            $display("still life frame does not show the block alone");
            errors++;
        end
        report("test 6 still life and die-out", errors - err0);
        report("test 5 blanking and sync", sync_errors);

        if (UUT.checks.fails != 0) begin
            $display("bound assertions on the engine and loader failed %0d times",
                     UUT.checks.fails);
            errors += UUT.checks.fails;
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(limit);
        $display("run timed out before all tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
